//--- common/rv32i_types_pkg.sv
// ################################################
// Base RV32I types shared by every block of the
// custom-instruction manager. Import it wherever a
// data word, register index or instruction field is used.
// ################################################

package rv32i_types_pkg;

  localparam int unsigned WORD_W   = 32; // width of one data word.
  localparam int unsigned REGSEL_W = 5;  // 32 architectural registers.

  typedef logic [WORD_W-1:0]   word_t;   // data word and raw instruction.
  typedef logic [REGSEL_W-1:0] regsel_t; // register file index.
  typedef logic [6:0]          opcode_t; // major opcode field.
  typedef logic [2:0]          funct3_t; // minor function field.
  typedef logic [6:0]          funct7_t; // upper function field of R-type words.

  // R-type view of an instruction word, listed from the most significant bit down.
  // Both custom opcodes use this layout, so the extensions decode through it.
  typedef struct packed {
    funct7_t funct7; // unused by the present extensions.
    regsel_t rs2;    // second source index.
    regsel_t rs1;    // first source index.
    funct3_t funct3; // selects the operation inside an extension.
    regsel_t rd;     // destination index.
    opcode_t opcode; // selects the extension.
  } rtype_t;

endpackage

//--- common/ext_mgmt_pkg.sv
// ################################################
// Request, claim and result types of the extension
// manager, with cause codes and opcode constants.
// Shared by the arbiter, both extensions and the testbench.
// ################################################

package ext_mgmt_pkg;

  import rv32i_types_pkg::*;

  typedef logic [1:0] ext_cause_t; // exception cause reported to the core.
  typedef logic       ext_idx_t;   // index of one extension.
  typedef logic [1:0] ext_vec_t;   // one bit per extension, indexed by ext_idx_t.

  localparam ext_idx_t EXT_BC  = 1'b0; // bit-count extension slot.
  localparam ext_idx_t EXT_MAC = 1'b1; // multiply-accumulate extension slot.

  // cause values equal the extension index, except for the unclaimed case.
  localparam ext_cause_t CAUSE_BC   = 2'd0; // illegal bit-count funct3.
  localparam ext_cause_t CAUSE_MAC  = 2'd1; // illegal multiply-accumulate funct3.
  localparam ext_cause_t CAUSE_NONE = 2'd3; // no extension claimed the word.

  localparam opcode_t OPC_CUSTOM0 = 7'b0001011; // claimed by the bit-count unit.
  localparam opcode_t OPC_CUSTOM1 = 7'b0101011; // claimed by the MAC unit.

  typedef enum funct3_t {
    BC_POPCNT = 3'd0, // number of set bits.
    BC_CLZ    = 3'd1, // leading zeros, 32 for a zero operand.
    BC_CTZ    = 3'd2, // trailing zeros, 32 for a zero operand.
    BC_REV    = 3'd3  // bit 0 swaps with bit 31 and so on.
  } bc_op_t;

  typedef enum funct3_t {
    MAC_MUL = 3'd0, // low word of rs1 * rs2.
    MAC_ACC = 3'd1, // accumulator += rs1 * rs2.
    MAC_CLR = 3'd2  // read and clear the accumulator.
  } mac_op_t;

  typedef struct packed {
    word_t insn;     // instruction word as fetched.
    word_t rs1_data; // first operand, already read by the core.
    word_t rs2_data; // second operand.
  } ext_req_t;

  typedef struct packed {
    logic    done;      // single-cycle pulse when the answer is valid.
    logic    exception; // the extension rejected the funct3.
    logic    reg_w;     // write rd with wdata.
    regsel_t rd;        // destination index.
    word_t   wdata;     // value to write.
  } ext_resp_t;

  typedef struct packed {
    regsel_t    rd;        // destination index.
    word_t      wdata;     // zero when exception is set.
    logic       reg_w;     // set only without exception and for rd other than x0.
    logic       exception; // instruction failed.
    ext_cause_t ex_cause;  // names the responsible extension.
  } ext_result_t;

endpackage

//--- src/ext_bitcount.sv
// ################################################
// Custom-0 extension with population count, leading and
// trailing zero count and bit reverse of rs1. It claims
// by opcode and answers one cycle after start.
// ################################################

`timescale 1ns/1ps

module ext_bitcount import rv32i_types_pkg::*, ext_mgmt_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  ext_req_t  ext_req, // request held by the arbiter.
  output logic      claim,   // combinational opcode match.
  input  logic      start,   // one-cycle start pulse.
  output ext_resp_t resp     // registered answer.
);

  rtype_t insn_f;  // field view of the instruction.
  word_t  rs1;     // only rs1 is an operand here.
  word_t  popcnt;  // number of ones in rs1.
  word_t  lzcnt;   // leading zeros in rs1.
  word_t  tzcnt;   // trailing zeros in rs1.
  word_t  rev;     // rs1 with its bit order reversed.
  word_t  result;  // value selected by funct3.
  logic   illegal; // funct3 outside the four operations.

  assign insn_f = ext_req.insn;
  assign rs1    = ext_req.rs1_data;
  assign claim  = (insn_f.opcode == OPC_CUSTOM0);

  always_comb begin
    popcnt = '0;
    lzcnt  = word_t'(32); // stays 32 when rs1 is zero.
    tzcnt  = word_t'(32);
    for (int i = 0; i < 32; i++) begin
      popcnt = popcnt + word_t'(rs1[i]);
      if (rs1[i]) lzcnt = word_t'(31 - i); // the highest set bit is seen last.
      rev[31-i] = rs1[i];
    end
    for (int i = 31; i >= 0; i--) begin
      if (rs1[i]) tzcnt = word_t'(i); // the lowest set bit is seen last.
    end
  end

  always_comb begin
    illegal = 1'b0;
    case (bc_op_t'(insn_f.funct3))
      BC_POPCNT: result = popcnt;
      BC_CLZ:    result = lzcnt;
      BC_CTZ:    result = tzcnt;
      BC_REV:    result = rev;
      default: begin
        result  = '0; // an illegal operation writes nothing.
        illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      resp <= '0;
    end else begin
      resp.done <= start; // done follows start by one cycle.
      if (start) begin
        resp.exception <= illegal;
        resp.reg_w     <= !illegal && (insn_f.rd != '0);
        resp.rd        <= insn_f.rd;
        resp.wdata     <= result;
      end
    end
  end

endmodule

//--- src/ext_mac.sv
// ################################################
// Custom-1 extension with a shift-add multiplier and a
// 32-bit accumulator. A multiply answers 32/MUL_STEP_BITS+1
// cycles after start, a clear or illegal op after one.
// ################################################

`timescale 1ns/1ps

module ext_mac import rv32i_types_pkg::*, ext_mgmt_pkg::*; #(
  parameter int unsigned MUL_STEP_BITS = 4 // multiplier bits handled per cycle.
) (
  input  logic      CLK,
  input  logic      rst_n,
  input  ext_req_t  ext_req, // request held by the arbiter.
  output logic      claim,   // combinational opcode match.
  input  logic      start,   // one-cycle start pulse.
  output ext_resp_t resp     // registered answer.
);

  localparam int unsigned STEPS = 32 / MUL_STEP_BITS; // cycles of the multiply phase.
  localparam int unsigned CNT_W = $clog2(STEPS);

  typedef enum logic {MAC_IDLE, MAC_BUSY} mac_state_t;

  if (!(MUL_STEP_BITS inside {1, 2, 4, 8})) begin : g_bad_step
    $error("MUL_STEP_BITS must be 1, 2, 4 or 8.");
  end

  mac_state_t       state_q;   // idle or multiplying.
  logic [CNT_W-1:0] cnt_q;     // steps already done.
  word_t            acc_q;     // architectural accumulator.
  word_t            mcand_q;   // multiplicand, shifted left each step.
  word_t            mplier_q;  // multiplier, shifted right each step.
  word_t            prod_q;    // partial product, low word only.
  word_t            prod_next; // partial product after this step.
  word_t            acc_sum;   // accumulator plus the finished product.
  mac_op_t          op;        // decoded funct3 of the request.
  mac_op_t          op_q;      // operation of the running multiply.
  regsel_t          rd_q;      // destination of the running multiply.
  rtype_t           insn_f;    // field view of the instruction.
  logic             legal;     // funct3 names a MAC operation.

  assign insn_f = ext_req.insn;
  assign claim  = (insn_f.opcode == OPC_CUSTOM1);
  assign op     = mac_op_t'(insn_f.funct3);

  always_comb begin
    case (op)
      MAC_MUL, MAC_ACC, MAC_CLR: legal = 1'b1;
      default:                   legal = 1'b0;
    endcase
  end

  // adds MUL_STEP_BITS shifted copies of the multiplicand per cycle.
  always_comb begin
    prod_next = prod_q;
    for (int b = 0; b < MUL_STEP_BITS; b++) begin
      if (mplier_q[b]) prod_next = prod_next + (mcand_q << b);
    end
  end

  assign acc_sum = acc_q + prod_next;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MAC_IDLE;
      cnt_q   <= '0;
      acc_q   <= '0;
      resp    <= '0;
    end else begin
      resp.done <= 1'b0; // done is a single-cycle pulse.
      case (state_q)
        MAC_IDLE: begin
          if (start && !legal) begin
            resp.done      <= 1'b1; // rejected at once while the accumulator stays untouched.
            resp.exception <= 1'b1;
            resp.reg_w     <= 1'b0;
            resp.rd        <= insn_f.rd;
            resp.wdata     <= '0;
          end else if (start && op == MAC_CLR) begin
            resp.done      <= 1'b1; // returns the old sum in one cycle.
            resp.exception <= 1'b0;
            resp.reg_w     <= (insn_f.rd != '0);
            resp.rd        <= insn_f.rd;
            resp.wdata     <= acc_q;
            acc_q          <= '0;
          end else if (start) begin
            state_q <= MAC_BUSY;
            cnt_q   <= '0;
          end
        end
        MAC_BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(STEPS - 1)) begin
            state_q        <= MAC_IDLE; // the last step completes here.
            resp.done      <= 1'b1;
            resp.exception <= 1'b0;
            resp.reg_w     <= (rd_q != '0);
            resp.rd        <= rd_q;
            if (op_q == MAC_ACC) begin
              acc_q      <= acc_sum;
              resp.wdata <= acc_sum;
            end else begin
              resp.wdata <= prod_next;
            end
          end
        end
        default: state_q <= MAC_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state_q == MAC_IDLE && start) begin
      mcand_q  <= ext_req.rs1_data;
      mplier_q <= ext_req.rs2_data;
      prod_q   <= '0;
      op_q     <= op;
      rd_q     <= insn_f.rd;
    end else if (state_q == MAC_BUSY) begin
      mcand_q  <= mcand_q << MUL_STEP_BITS;
      mplier_q <= mplier_q >> MUL_STEP_BITS;
      prod_q   <= prod_next;
    end
  end

endmodule

//--- ext_mgmt/ext_arbiter.sv
// ################################################
// Arbiter of the extension manager. It accepts one request,
// starts the claiming extension, turns the answer into one
// writeback record and holds it until the core takes it.
// ################################################

`timescale 1ns/1ps

module ext_arbiter import rv32i_types_pkg::*, ext_mgmt_pkg::*; (
  input  logic        CLK,
  input  logic        rst_n,
  input  ext_req_t    req,
  input  logic        req_valid,
  output logic        req_ready,
  output ext_result_t res,
  output logic        res_valid,
  input  logic        res_ready,
  output ext_req_t    ext_req,
  input  logic        bc_claim,
  input  logic        mac_claim,
  output logic        bc_start,
  output logic        mac_start,
  input  ext_resp_t   bc_resp,
  input  ext_resp_t   mac_resp
);

  typedef enum logic [1:0] {IDLE, WAIT_EXT, HOLD_RES} arb_state_t;

  arb_state_t        state_q, state_d; // sequencing of one instruction.
  ext_req_t          req_q;            // request held for the whole transaction.
  logic              start_pend_q;     // first cycle after acceptance.
  ext_result_t       res_q, res_d;     // result register toward the core.
  ext_vec_t          tokens;           // one claim token per extension.
  ext_vec_t          start_vec;        // start pulses, one per extension.
  logic              ext_is_active;    // at least one extension claimed.
  ext_idx_t          active_ext;       // highest claiming index.
  ext_resp_t [1:0]   resps;            // answers, indexed like tokens.
  ext_resp_t         act_resp;         // answer of the active extension.
  rtype_t            insn_f;           // field view of the held instruction.
  logic              accept;           // request handshake on this edge.

  assign req_ready = (state_q == IDLE);     // busy from acceptance to result handshake.
  assign res_valid = (state_q == HOLD_RES);
  assign res       = res_q;
  assign accept    = req_valid && req_ready;
  assign ext_req   = req_q;                 // claims are decoded from the held word.
  assign insn_f    = req_q.insn;

  assign tokens[EXT_BC]  = bc_claim;
  assign tokens[EXT_MAC] = mac_claim;
  assign ext_is_active   = |tokens;

  // later indices win, so the highest claiming extension is active.
  always_comb begin
    active_ext = EXT_BC;
    for (int i = 0; i < $bits(ext_vec_t); i++) begin
      if (tokens[i]) active_ext = ext_idx_t'(i);
    end
  end

  assign resps[EXT_BC]  = bc_resp;
  assign resps[EXT_MAC] = mac_resp;
  assign act_resp       = resps[active_ext];

  always_comb begin
    start_vec = '0;
    if (state_q == WAIT_EXT && start_pend_q && ext_is_active) begin
      start_vec[active_ext] = 1'b1; // only the active extension is started.
    end
  end

  assign bc_start  = start_vec[EXT_BC];
  assign mac_start = start_vec[EXT_MAC];

  always_comb begin
    state_d = state_q;
    res_d   = res_q;
    case (state_q)
      IDLE: begin
        if (accept) state_d = WAIT_EXT;
      end
      WAIT_EXT: begin
        if (start_pend_q && !ext_is_active) begin
          res_d.rd        = insn_f.rd; // nobody claimed, so the arbiter answers itself.
          res_d.wdata     = '0;
          res_d.reg_w     = 1'b0;
          res_d.exception = 1'b1;
          res_d.ex_cause  = CAUSE_NONE;
          state_d         = HOLD_RES;
        end else if (!start_pend_q && act_resp.done) begin
          res_d.rd        = act_resp.rd;
          res_d.wdata     = act_resp.exception ? '0 : act_resp.wdata;
          res_d.reg_w     = act_resp.reg_w && !act_resp.exception && (act_resp.rd != '0);
          res_d.exception = act_resp.exception;
          res_d.ex_cause  = ext_cause_t'(active_ext); // cause is the extension index.
          state_d         = HOLD_RES;
        end
      end
      HOLD_RES: begin
        if (res_ready) state_d = IDLE; // result taken, ready for the next request.
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      start_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      start_pend_q <= accept; // high for exactly one cycle after acceptance.
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) req_q <= req;
    res_q <= res_d;
  end

endmodule

//--- ext_mgmt/ext_mgmt.sv
// ################################################
// Top level of the custom-instruction manager. The core
// hands one instruction with its operands over the request
// channel and receives one writeback record per request.
// ################################################

`timescale 1ns/1ps

module ext_mgmt import ext_mgmt_pkg::*; #(
  parameter int unsigned MUL_STEP_BITS = 4 // multiplier bits retired per cycle in ext_mac.
) (
  input  logic        CLK,       // core clock.
  input  logic        rst_n,     // asynchronous reset, active low.
  input  ext_req_t    req,       // instruction and operands from the core.
  input  logic        req_valid, // core offers req.
  output logic        req_ready, // manager is idle and takes req.
  output ext_result_t res,       // writeback record for the core.
  output logic        res_valid, // res is valid and held.
  input  logic        res_ready  // core takes res.
);

  ext_req_t  ext_req;   // accepted request, broadcast to every extension.
  logic      bc_claim;  // bit-count unit decodes ext_req as its own.
  logic      mac_claim; // MAC unit decodes ext_req as its own.
  logic      bc_start;  // one-cycle start pulse to the bit-count unit.
  logic      mac_start; // one-cycle start pulse to the MAC unit.
  ext_resp_t bc_resp;   // registered answer of the bit-count unit.
  ext_resp_t mac_resp;  // registered answer of the MAC unit.

  // the arbiter owns both core channels and sequences the extensions.
  ext_arbiter arbiter_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .ext_req   (ext_req),
    .bc_claim  (bc_claim),
    .mac_claim (mac_claim),
    .bc_start  (bc_start),
    .mac_start (mac_start),
    .bc_resp   (bc_resp),
    .mac_resp  (mac_resp)
  );

  // custom-0 decoder, answers one cycle after start.
  ext_bitcount bitcount_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .ext_req (ext_req),
    .claim   (bc_claim),
    .start   (bc_start),
    .resp    (bc_resp)
  );

  // custom-1 decoder with its own accumulator.
  ext_mac #(
    .MUL_STEP_BITS (MUL_STEP_BITS)
  ) mac_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .ext_req (ext_req),
    .claim   (mac_claim),
    .start   (mac_start),
    .resp    (mac_resp)
  );

endmodule

//--- test/ext_mgmt_asserts.sv
// ##################################################
// Handshake and claim assertions of the extension
// arbiter, attached to every ext_arbiter by bind.
// ##################################################

`timescale 1ns/1ps

module ext_mgmt_asserts import ext_mgmt_pkg::*; (
  input logic        CLK,
  input logic        rst_n,
  input logic        req_ready,
  input ext_result_t res,
  input logic        res_valid,
  input logic        res_ready,
  input logic        bc_claim,
  input logic        mac_claim
);

  int unsigned fail_cnt = 0; // failed assertions so far, watched by the testbench.

  // a pending result keeps its value until the core takes it.
  a_res_held: assert property (@(posedge CLK) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res))
    else begin
      fail_cnt++;
      $error("result changed or dropped while the core stalled.");
    end

  // the held request is only defined while busy.
  a_one_claim: assert property (@(posedge CLK) disable iff (!rst_n)
    !req_ready |-> !(bc_claim && mac_claim))
    else begin
      fail_cnt++;
      $error("both extensions claimed the same instruction.");
    end

  a_busy: assert property (@(posedge CLK) disable iff (!rst_n)
    res_valid |-> !req_ready)
    else begin
      fail_cnt++;
      $error("a new request was offered while a result was pending.");
    end

endmodule

bind ext_arbiter ext_mgmt_asserts asserts_i (.*);

//--- test/tb_ext_mgmt.sv
// ##################################################
// Self-checking testbench of the extension manager. It
// sends directed and LFSR-random instructions, predicts
// each writeback record and compares it with the DUT.
// ##################################################

`timescale 1ns/1ps

module tb_ext_mgmt import rv32i_types_pkg::*, ext_mgmt_pkg::*; ();

  localparam int unsigned MUL_STEP_BITS = 4;  // multiplier bits per cycle in the DUT.
  localparam int unsigned N_DIRECTED    = 34; // directed instructions issued first.
  localparam int unsigned N_RANDOM      = 80; // random instructions issued after them.
  localparam int unsigned CYC_PER_INSN  = 32 / MUL_STEP_BITS + 20; // worst case per instruction.
  localparam int unsigned CLK_NS        = 8;

  logic        CLK;
  logic        rst_n;
  ext_req_t    req;
  logic        req_valid;
  logic        req_ready;
  ext_result_t res;
  logic        res_valid;
  logic        res_ready;
  logic [31:0] lfsr_q;    // state of the stimulus generator.
  word_t       model_acc; // accumulator as the model sees it.

  ext_mgmt #(.MUL_STEP_BITS(MUL_STEP_BITS)) dut_i (.*);

  initial CLK = 1'b0;
  always #(CLK_NS / 2) CLK = ~CLK;

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error.");
  endtask

  task automatic check_result(input string name, input ext_result_t exp, input ext_result_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_cause(input string name, input ext_cause_t exp, input ext_cause_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s cause: expected %0d, actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic verify_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  // taps 32, 22, 2 and 1, one step for every bit handed out.
  function automatic word_t rand_bits(input int unsigned n);
    word_t val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic word_t bitcount_ref(input word_t x, input funct3_t f3);
    word_t n;
    n = '0;
    case (f3)
      BC_POPCNT: n = word_t'($countones(x));
      BC_CLZ:    for (int i = 31; i >= 0 && !x[i]; i--) n++; // stops at the top set bit.
      BC_CTZ:    for (int i = 0; i < 32 && !x[i]; i++) n++;  // stops at the lowest set bit.
      default:   for (int i = 0; i < 32; i++) n[i] = x[31-i];
    endcase
    return n;
  endfunction

  // predicts one writeback record and advances the model accumulator.
  function automatic ext_result_t model_result(input ext_req_t r);
    rtype_t      f;
    ext_result_t e;
    logic [63:0] prod;
    f    = r.insn;
    e    = '0;
    e.rd = f.rd;
    prod = {32'd0, r.rs1_data} * {32'd0, r.rs2_data}; // only the low word is kept.
    if (f.opcode == OPC_CUSTOM0) begin
      e.ex_cause = CAUSE_BC;
      if (f.funct3 < 3'd4) e.wdata = bitcount_ref(r.rs1_data, f.funct3);
      else e.exception = 1'b1;
    end else if (f.opcode == OPC_CUSTOM1) begin
      e.ex_cause = CAUSE_MAC;
      case (f.funct3)
        MAC_MUL: e.wdata = prod[31:0];
        MAC_ACC: begin
          model_acc = model_acc + prod[31:0];
          e.wdata   = model_acc;
        end
        MAC_CLR: begin
          e.wdata   = model_acc; // the old sum is returned before clearing.
          model_acc = '0;
        end
        default: e.exception = 1'b1;
      endcase
    end else begin
      e.exception = 1'b1;
      e.ex_cause  = CAUSE_NONE;
    end
    e.reg_w = !e.exception && (f.rd != '0);
    return e;
  endfunction

  function automatic ext_req_t make_req(input opcode_t opc, input funct3_t f3, input regsel_t rd,
                                        input word_t a, input word_t b);
    rtype_t f;
    f = '{funct7: '0, rs2: regsel_t'(rand_bits(5)), rs1: regsel_t'(rand_bits(5)),
          funct3: f3, rd: rd, opcode: opc};
    return '{insn: f, rs1_data: a, rs2_data: b};
  endfunction

  // one full transaction with a random idle gap and a random result stall.
  task automatic run_insn(input string name, input ext_req_t r);
    ext_result_t exp;
    int unsigned gap;
    int unsigned stall;
    exp   = model_result(r);
    gap   = rand_bits(2);
    stall = rand_bits(2);
    repeat (gap) begin
      verify_flag({name, " no extra result"}, 1'b0, res_valid);
      @(negedge CLK);
    end
    verify_flag({name, " idle ready"}, 1'b1, req_ready);
    req       = r;
    req_valid = 1'b1;
    @(negedge CLK);
    req_valid = 1'b0; // accepted on the edge just passed.
    while (!res_valid) begin
      verify_flag({name, " busy"}, 1'b0, req_ready);
      @(negedge CLK);
    end
    for (int i = 0; i <= stall; i++) begin
      verify_flag({name, " held valid"}, 1'b1, res_valid);
      verify_flag({name, " held ready"}, 1'b0, req_ready);
      check_cause(name, exp.ex_cause, res.ex_cause);
      check_result(name, exp, res); // must not change while stalled.
      if (i == stall) res_ready = 1'b1;
      @(negedge CLK);
    end
    res_ready = 1'b0;
    verify_flag({name, " taken"}, 1'b0, res_valid);
  endtask

  // the watchdog allows every instruction its worst-case length.
  initial begin
    #((N_DIRECTED + N_RANDOM) * CYC_PER_INSN * CLK_NS);
    $display("timeout: a result never arrived within the expected time.");
    stop_on_error();
  end

  always @(negedge CLK) begin
    if (dut_i.arbiter_i.asserts_i.fail_cnt != 0) begin
      $display("a bound assertion on the arbiter failed.");
      stop_on_error();
    end
  end

  initial begin
    word_t   operands [3];
    opcode_t opc;
    lfsr_q    = 32'h1ccb;
    model_acc = '0;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    res_ready = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    verify_flag("reset ready", 1'b1, req_ready);
    verify_flag("reset valid", 1'b0, res_valid);
    operands = '{32'h0, 32'hffff_ffff, rand_bits(32)}; // edge operands first.
    for (int f = 0; f < 4; f++) begin
      foreach (operands[k]) begin
        run_insn("bitcount", make_req(OPC_CUSTOM0, funct3_t'(f), regsel_t'(rand_bits(5)),
                                      operands[k], rand_bits(32)));
      end
    end
    run_insn("mac clear", make_req(OPC_CUSTOM1, MAC_CLR, 5'd3, '0, '0));
    run_insn("mac multiply", make_req(OPC_CUSTOM1, MAC_MUL, 5'd4, rand_bits(32), rand_bits(32)));
    repeat (3) run_insn("mac accumulate",
                        make_req(OPC_CUSTOM1, MAC_ACC, 5'd5, rand_bits(32), rand_bits(32)));
    run_insn("mac clear sum", make_req(OPC_CUSTOM1, MAC_CLR, 5'd6, '0, '0));
    run_insn("mac restart", make_req(OPC_CUSTOM1, MAC_ACC, 5'd7, rand_bits(32), rand_bits(32)));
    for (int f = 4; f < 8; f++) begin
      run_insn("bitcount illegal", make_req(OPC_CUSTOM0, funct3_t'(f), 5'd8, rand_bits(32), '0));
    end
    run_insn("mac before illegal", make_req(OPC_CUSTOM1, MAC_ACC, 5'd9, rand_bits(32), 32'd3));
    for (int f = 3; f < 8; f++) begin
      run_insn("mac illegal", make_req(OPC_CUSTOM1, funct3_t'(f), 5'd10, rand_bits(32), 32'd5));
    end
    run_insn("mac after illegal", make_req(OPC_CUSTOM1, MAC_CLR, 5'd11, '0, '0));
    run_insn("unclaimed op", make_req(7'b0110011, 3'd0, 5'd12, rand_bits(32), rand_bits(32)));
    run_insn("unclaimed load", make_req(7'b0000011, 3'd2, 5'd13, rand_bits(32), '0));
    run_insn("bitcount rd0", make_req(OPC_CUSTOM0, BC_POPCNT, 5'd0, 32'hffff_ffff, '0));
    run_insn("mac rd0", make_req(OPC_CUSTOM1, MAC_MUL, 5'd0, rand_bits(32), rand_bits(32)));
    repeat (N_RANDOM) begin
      case (rand_bits(2))
        32'd0:   opc = OPC_CUSTOM0;
        32'd1:   opc = OPC_CUSTOM1;
        32'd2:   opc = 7'b0110011; // plain R-type, claimed by nobody.
        default: opc = opcode_t'(rand_bits(7));
      endcase
      run_insn("random", make_req(opc, funct3_t'(rand_bits(3)), regsel_t'(rand_bits(5)),
                                  rand_bits(32), rand_bits(32)));
    end
    @(negedge CLK);
    if (dut_i.arbiter_i.asserts_i.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("a bound assertion on the arbiter failed.");
      stop_on_error();
    end
  end

endmodule

//--- flist.f
common/rv32i_types_pkg.sv
common/ext_mgmt_pkg.sv
src/ext_bitcount.sv
src/ext_mac.sv
ext_mgmt/ext_arbiter.sv
ext_mgmt/ext_mgmt.sv
test/ext_mgmt_asserts.sv
test/tb_ext_mgmt.sv

//--- Bender.yml
package:
  name: ext_mgmt

sources:
  - common/rv32i_types_pkg.sv
  - common/ext_mgmt_pkg.sv
  - src/ext_bitcount.sv
  - src/ext_mac.sv
  - ext_mgmt/ext_arbiter.sv
  - ext_mgmt/ext_mgmt.sv
  - target: test
    files:
      - test/ext_mgmt_asserts.sv
      - test/tb_ext_mgmt.sv
